// File: dv/soc_ctrl_golden.txt
# op test addr wdata rdata err, all hex except the decimal test number
# W write, R read, X random pad window, C pad outputs, O side-band output,
# J jtag input, T watchdog ticks, S timeout start, P peripheral timeout pulse
R 1 000 00000000 00040000 0
R 1 004 00000000 1A000080 0
R 1 008 00000000 00000001 0
C 1 000 00000000 00003F00 0
C 1 03F 00000000 00003F00 0
W 2 004 1C008000 00000000 0
R 2 004 00000000 1C008000 0
O 2 000 00000000 1C008000 0
W 2 008 00000000 00000000 0
R 2 008 00000000 00000000 0
O 2 001 00000000 00000000 0
W 2 074 000000A5 00000000 0
J 2 000 0000003C 00000000 0
R 2 074 00000000 00003CA5 0
O 2 002 00000000 000000A5 0
W 3 414 00002A03 00000000 0
R 3 414 00000000 00002A03 0
C 3 005 00000000 00002A03 0
W 3 060 15020009 00000000 0
R 3 064 00000000 15020009 0
C 3 009 00000000 00001502 0
W 3 064 00000005 00000000 0
R 3 060 00000000 2A030005 0
R 3 500 00000000 0095BEEF 0
X 3 444 00000000 00000000 0
X 3 4FC 00000000 00000000 0
R 4 010 00000000 DEADBEEF 1
W 4 200 12345678 00000000 1
R 4 3F0 00000000 DEADBEEF 1
W 5 0D0 00000005 00000000 0
W 5 0D4 00000001 00000000 0
R 5 0D4 00000000 80000005 0
W 5 0D0 00000100 00000000 0
R 5 0D0 00000000 00000005 0
T 5 000 00000003 00000000 0
W 5 0D4 00006699 00000000 0
T 5 000 00000004 00000000 0
O 5 003 00000000 00000000 0
T 5 000 00000002 00000000 0
O 5 003 00000000 00000001 0
W 6 0E4 0000000A 00000000 0
R 6 0E4 00000000 0000000F 0
S 6 000 00000001 00000010 0
S 6 000 00000000 00000000 0
P 6 000 00000005 00000000 0
R 6 0E0 00000000 00000005 0
P 6 000 00000002 00000000 0
R 6 0E0 00000000 00000007 0
W 6 0E0 00000000 00000000 0
R 6 0E0 00000000 00000000 0
W 6 414 00001F01 00000000 0
P 6 000 00000008 00000000 0
W 6 0FC 00000001 00000000 0
O 6 004 00000000 00000001 0
R 6 0E4 00000000 000000FF 0
R 6 0E0 00000000 00000000 0
C 6 005 00000000 00003F00 0

// File: flist.f
source/soc_ctrl_pkg.sv
source/soc_reg_if.sv
source/soc_wd_if.sv
source/soc_ctrl_apb_fsm.sv
source/soc_ctrl_regs.sv
source/soc_ctrl_watchdog.sv
source/soc_ctrl_rto.sv
source/soc_ctrl_top.sv
dv/tb_soc_ctrl.sv

// File: Makefile
# Verilator build and run of the SoC control block testbench

SRCS := $(wildcard source/*.sv) $(wildcard dv/*.sv)
BIN  := obj_dir/Vtb_soc_ctrl

.PHONY: all run clean

all: $(BIN)

$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_ctrl \
		-Mdir obj_dir -f flist.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_soc_ctrl.sv
// Testbench for the SoC control block
// Replays APB accesses and side-band actions from a golden file and checks
// read data, error flags and side-band outputs

`timescale 1ns/1ps

module tb_soc_ctrl;

  localparam int CLK_PERIOD    = 40;
  localparam int N_IO          = 64;
  localparam int NBIT_PADCFG   = 6;
  localparam int NBIT_PADMUX   = 2;
  localparam int JTAG_REG_SIZE = 8;
  localparam int NB_MASTER     = 4;
  localparam int WIN_CFG_POS   = 8;  // Cfg field in a pad window word

  logic HCLK;
  logic HRESETn;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic pwrite;
  logic psel;
  logic penable;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic ref_clk;
  logic stoptimer;
  logic wd_expired;
  logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg;
  logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux;
  logic [JTAG_REG_SIZE-1:0] jtag_in;
  logic [JTAG_REG_SIZE-1:0] jtag_out;
  logic [31:0] bootaddr;
  logic fetchen;
  logic start_rto;
  logic [NB_MASTER-1:0] periph_rto;
  logic rto;
  logic soft_reset;

  byte op_q[$];
  int test_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] wdata_q[$];
  logic [31:0] rdata_q[$];
  logic [31:0] err_q[$];

  logic [31:0] rd_data;
  logic [31:0] rd_err;
  int limit_ns = 0;
  int soft_pulses = 0;
  int n_checks = 0;
  int n_errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  soc_ctrl_top #(
    .N_IO (N_IO), .NBIT_PADCFG (NBIT_PADCFG), .NBIT_PADMUX (NBIT_PADMUX),
    .JTAG_REG_SIZE (JTAG_REG_SIZE), .NB_MASTER (NB_MASTER)
  ) u_dut (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .paddr_i (paddr), .pwdata_i (pwdata), .pwrite_i (pwrite), .psel_i (psel),
    .penable_i (penable), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .ref_clk_i (ref_clk), .stoptimer_i (stoptimer), .wd_expired_o (wd_expired),
    .pad_cfg_o (pad_cfg), .pad_mux_o (pad_mux),
    .soc_jtag_reg_i (jtag_in), .soc_jtag_reg_o (jtag_out),
    .fc_bootaddr_o (bootaddr), .fc_fetchen_o (fetchen),
    .start_rto_i (start_rto), .peripheral_rto_i (periph_rto), .rto_o (rto),
    .soft_reset_o (soft_reset)
  );

  initial HCLK = 1'b0;
  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  always @(negedge HCLK) begin
    if (soft_reset === 1'b1) soft_pulses++;  // Width of the soft reset pulse in cycles
  end

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] data);
    @(negedge HCLK);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge HCLK);
    penable = 1'b1;  // Access phase held until PREADY
    @(negedge HCLK);
    while (!pready) @(negedge HCLK);
    rd_data = prdata;
    rd_err  = {31'd0, pslverr};
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    test_checks++;
    if (got !== exp) begin
      $display("error %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      n_errors++;
      test_errors++;
    end
  endtask

  function automatic logic [31:0] pad_word(input logic [31:0] k);
    logic [31:0] word;
    word = '0;
    word[NBIT_PADMUX-1:0] = pad_mux[k[7:0]];
    word[WIN_CFG_POS +: NBIT_PADCFG] = pad_cfg[k[7:0]];
    return word;
  endfunction

  function automatic logic [31:0] side_value(input logic [31:0] sel);
    case (sel)
      0:       return bootaddr;
      1:       return {31'd0, fetchen};
      2:       return {24'd0, jtag_out};
      3:       return {31'd0, wd_expired};
      default: return soft_pulses;
    endcase
  endfunction

  task automatic run_line(input int i);
    logic [31:0] rnd;
    logic [31:0] exp;
    int waited;
    case (op_q[i])
      "W": begin
        apb_access(1'b1, addr_q[i][11:0], wdata_q[i]);
        check_value("write error flag", rd_err, err_q[i]);
      end
      "R": begin
        apb_access(1'b0, addr_q[i][11:0], '0);
        check_value("read data", rd_data, rdata_q[i]);
        check_value("read error flag", rd_err, err_q[i]);
      end
      "X": begin
        rnd = $urandom;
        exp = '0;
        exp[NBIT_PADMUX-1:0] = rnd[NBIT_PADMUX-1:0];
        exp[WIN_CFG_POS +: NBIT_PADCFG] = rnd[WIN_CFG_POS +: NBIT_PADCFG];
        apb_access(1'b1, addr_q[i][11:0], rnd);
        apb_access(1'b0, addr_q[i][11:0], '0);
        check_value("pad window read", rd_data, exp);
        check_value("pad outputs", pad_word({24'd0, addr_q[i][9:2]}), exp);
      end
      "C": begin
        @(negedge HCLK);
        check_value("pad outputs", pad_word(addr_q[i]), rdata_q[i]);
      end
      "O": begin
        @(negedge HCLK);
        check_value("side-band output", side_value(addr_q[i]), rdata_q[i]);
      end
      "J": begin
        @(negedge HCLK);
        jtag_in = wdata_q[i][JTAG_REG_SIZE-1:0];
      end
      "T": begin
        repeat (wdata_q[i]) begin
          @(negedge HCLK);
          ref_clk = 1'b1;  // One tick per high cycle
          @(negedge HCLK);
          ref_clk = 1'b0;
        end
      end
      "S": begin
        @(negedge HCLK);
        start_rto = wdata_q[i][0];
        waited = 0;
        if (wdata_q[i][0]) begin
          while (!rto) begin
            @(negedge HCLK);
            waited++;
          end
          check_value("cycles to timeout", waited, rdata_q[i]);
        end
      end
      "P": begin
        @(negedge HCLK);
        periph_rto = wdata_q[i][NB_MASTER-1:0];
        @(negedge HCLK);
        periph_rto = '0;
      end
      default: begin
        $display("golden entry %0d has an unknown operation", i);
        n_errors++;
        test_errors++;
      end
    endcase
  endtask

  task automatic finish_test(input int num);
    $display("test %0d finished: %0d checks, %0d errors", num, test_checks, test_errors);
    if (test_errors == 0) tests_passed++;
    else tests_failed++;
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    string line;
    int fd;
    int cur_test;
    int tick_cycles;
    byte op;
    int tnum;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] e;
    HRESETn = 1'b0;
    {paddr, pwdata, pwrite, psel, penable} = '0;
    {ref_clk, stoptimer, jtag_in, start_rto, periph_rto} = '0;
    rd_data = $urandom(32'he833_bf61);  // Seeds the generator once
    fd = $fopen("dv/soc_ctrl_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open the golden file dv/soc_ctrl_golden.txt");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      tick_cycles = 0;
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%c %d %h %h %h %h", op, tnum, a, w, r, e) == 6) begin
          op_q.push_back(op);
          test_q.push_back(tnum);
          addr_q.push_back(a);
          wdata_q.push_back(w);
          rdata_q.push_back(r);
          err_q.push_back(e);
          if (op == "T") tick_cycles += 2 * int'(w);
        end
      end
      $fclose(fd);
      limit_ns = (op_q.size() * 10 + tick_cycles + 10) * CLK_PERIOD;

      repeat (2) @(negedge HCLK);
      HRESETn = 1'b1;
      cur_test = 0;
      for (int i = 0; i < op_q.size(); i++) begin
        if (test_q[i] != cur_test) begin
          if (cur_test != 0) finish_test(cur_test);
          cur_test = test_q[i];
        end
        run_line(i);
      end
      finish_test(cur_test);
      $display("tests passed %0d, failed %0d; checks %0d, errors %0d",
               tests_passed, tests_failed, n_checks, n_errors);
      if (n_errors == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout: the run was still busy after %0d ns", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: source/soc_ctrl_top.sv
// SoC control block top level
// APB slave with boot, pad, JTAG, watchdog and ready-timeout control

`timescale 1ns/1ps

module soc_ctrl_top #(
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_CLUSTERS   = 0,
  parameter int unsigned N_IO          = 64,
  parameter int unsigned NBIT_PADCFG   = 6,
  parameter int unsigned NBIT_PADMUX   = 2,
  parameter int unsigned JTAG_REG_SIZE = 8,
  parameter int unsigned NB_MASTER     = 4
) (
  input  logic                             HCLK,
  input  logic                             HRESETn,

  input  logic [11:0]                      paddr_i,
  input  logic [31:0]                      pwdata_i,
  input  logic                             pwrite_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,

  input  logic                             ref_clk_i,
  input  logic                             stoptimer_i,
  output logic                             wd_expired_o,

  output logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux_o,

  input  logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_i,
  output logic [JTAG_REG_SIZE-1:0]         soc_jtag_reg_o,

  output logic [31:0]                      fc_bootaddr_o,
  output logic                             fc_fetchen_o,

  input  logic                             start_rto_i,
  input  logic [NB_MASTER-1:0]             peripheral_rto_i,
  output logic                             rto_o,
  output logic                             soft_reset_o
);

  logic [19:0]          rto_reload;
  logic                 rto_clear;
  logic [NB_MASTER-1:0] periph_flags;

  soc_reg_if u_reg_if ();
  soc_wd_if  u_wd_if ();

  soc_ctrl_apb_fsm u_apb_fsm (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pwrite_i  (pwrite_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .reg_o     (u_reg_if.master)
  );

  soc_ctrl_regs #(
    .NB_CORES      (NB_CORES),
    .NB_CLUSTERS   (NB_CLUSTERS),
    .N_IO          (N_IO),
    .NBIT_PADCFG   (NBIT_PADCFG),
    .NBIT_PADMUX   (NBIT_PADMUX),
    .JTAG_REG_SIZE (JTAG_REG_SIZE),
    .NB_MASTER     (NB_MASTER)
  ) u_regs (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .reg_i          (u_reg_if.slave),
    .wd_o           (u_wd_if.ctrl),
    .soc_jtag_reg_i (soc_jtag_reg_i),
    .periph_flags_i (periph_flags),
    .soc_jtag_reg_o (soc_jtag_reg_o),
    .fc_bootaddr_o  (fc_bootaddr_o),
    .fc_fetchen_o   (fc_fetchen_o),
    .pad_cfg_o      (pad_cfg_o),
    .pad_mux_o      (pad_mux_o),
    .rto_reload_o   (rto_reload),
    .rto_clear_o    (rto_clear),
    .soft_reset_o   (soft_reset_o)
  );

  soc_ctrl_watchdog u_watchdog (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .ref_clk_i    (ref_clk_i),
    .stoptimer_i  (stoptimer_i),
    .wd_i         (u_wd_if.timer),
    .wd_expired_o (wd_expired_o)
  );

  soc_ctrl_rto #(
    .NB_MASTER (NB_MASTER)
  ) u_rto (
    .HCLK             (HCLK),
    .HRESETn          (HRESETn),
    .start_rto_i      (start_rto_i),
    .peripheral_rto_i (peripheral_rto_i),
    .rto_reload_i     (rto_reload),
    .rto_clear_i      (rto_clear),
    .rto_o            (rto_o),
    .periph_flags_o   (periph_flags)
  );

endmodule

// File: source/soc_ctrl_rto.sv
// Ready-timeout monitor
// Counts down while a transfer waits for ready, flags a timeout at zero,
// and accumulates sticky per-peripheral timeout flags

`timescale 1ns/1ps

module soc_ctrl_rto #(
  parameter int unsigned NB_MASTER = 4
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 start_rto_i,
  input  logic [NB_MASTER-1:0] peripheral_rto_i,
  input  logic [19:0]          rto_reload_i,
  input  logic                 rto_clear_i,
  output logic                 rto_o,
  output logic [NB_MASTER-1:0] periph_flags_o
);

  logic [19:0] count_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      count_q        <= soc_ctrl_pkg::RTO_RESET_COUNT;
      rto_o          <= 1'b0;
      periph_flags_o <= '0;
    end else begin
      if (start_rto_i) count_q <= count_q - 20'd1;
      else             count_q <= rto_reload_i;  // Idle keeps the counter reloaded

      rto_o <= (count_q == '0);

      if (rto_clear_i) periph_flags_o <= '0;
      else             periph_flags_o <= periph_flags_o | peripheral_rto_i;
    end
  end

endmodule

// File: source/soc_ctrl_watchdog.sv
// Watchdog timer
// 31-bit down-counter ticking on the reference-clock strobe, reloaded
// by start and kick, with expiry held until reset

`timescale 1ns/1ps

module soc_ctrl_watchdog (
  input  logic     HCLK,
  input  logic     HRESETn,
  input  logic     ref_clk_i,    // Tick strobe in the HCLK domain
  input  logic     stoptimer_i,  // Freezes the count, e.g. under debug
  soc_wd_if.timer  wd_i,
  output logic     wd_expired_o
);

  logic [30:0] count_q;
  logic        enabled_q;
  logic        expired_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      count_q   <= soc_ctrl_pkg::WD_RESET_COUNT;
      enabled_q <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      if (wd_i.start) enabled_q <= 1'b1;  // No way back except reset

      if (wd_i.start || wd_i.kick) begin
        count_q <= wd_i.load_value;
      end else if (enabled_q && ref_clk_i && !stoptimer_i) begin
        count_q <= count_q - 31'd1;
      end

      if (enabled_q && count_q == '0) expired_q <= 1'b1;
    end
  end

  assign wd_i.enabled = enabled_q;
  assign wd_i.expired = expired_q;
  assign wd_expired_o = expired_q;

  // Expiry is sticky until the next reset
  a_expired_sticky: assert property (
    @(posedge HCLK) disable iff (!HRESETn) expired_q |=> expired_q
  );

endmodule

// File: source/soc_ctrl_regs.sv
// SoC control register bank
// Decodes register and pad-window accesses, holds boot, pad, JTAG,
// watchdog and timeout configuration, and generates soft reset

`timescale 1ns/1ps

module soc_ctrl_regs #(
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_CLUSTERS   = 0,
  parameter int unsigned N_IO          = 64,
  parameter int unsigned NBIT_PADCFG   = 6,
  parameter int unsigned NBIT_PADMUX   = 2,
  parameter int unsigned JTAG_REG_SIZE = 8,
  parameter int unsigned NB_MASTER     = 4
) (
  input  logic                                HCLK,
  input  logic                                HRESETn,

  soc_reg_if.slave                            reg_i,
  soc_wd_if.ctrl                              wd_o,

  input  logic [JTAG_REG_SIZE-1:0]            soc_jtag_reg_i,
  input  logic [NB_MASTER-1:0]                periph_flags_i,

  output logic [JTAG_REG_SIZE-1:0]            soc_jtag_reg_o,
  output logic [31:0]                         fc_bootaddr_o,
  output logic                                fc_fetchen_o,
  output logic [N_IO-1:0][NBIT_PADCFG-1:0]    pad_cfg_o,
  output logic [N_IO-1:0][NBIT_PADMUX-1:0]    pad_mux_o,
  output logic [19:0]                         rto_reload_o,
  output logic                                rto_clear_o,
  output logic                                soft_reset_o
);

  localparam int IDX_WIDTH = $clog2(N_IO);

  soc_ctrl_pkg::reg_offset_e offs;

  logic [IDX_WIDTH-1:0]     sel_pad_q;
  logic [IDX_WIDTH-1:0]     wr_pad;
  logic [7:0]               win_idx;
  logic                     win_hit;
  logic                     win_in_range;
  logic [JTAG_REG_SIZE-1:0] jtag_sync0_q;
  logic [JTAG_REG_SIZE-1:0] jtag_sync1_q;
  logic [30:0]              wd_count_q;
  logic [31:0]              rd_value;
  logic                     rd_hit;

  assign offs         = soc_ctrl_pkg::reg_offset_e'(reg_i.addr);
  assign win_hit      = (reg_i.addr[11:10] == soc_ctrl_pkg::PAD_WINDOW_BASE[11:10]);
  assign win_idx      = reg_i.addr[9:2];
  assign win_in_range = (win_idx < N_IO);
  assign wr_pad       = reg_i.wdata[soc_ctrl_pkg::WCFG_IDX_POS +: IDX_WIDTH];

  assign wd_o.load_value = wd_count_q;

  // Read decode
  always_comb begin
    rd_value = '0;
    rd_hit   = 1'b1;
    if (win_hit) begin
      if (win_in_range) begin
        rd_value[soc_ctrl_pkg::WIN_MUX_POS +: NBIT_PADMUX] = pad_mux_o[win_idx[IDX_WIDTH-1:0]];
        rd_value[soc_ctrl_pkg::WIN_CFG_POS +: NBIT_PADCFG] = pad_cfg_o[win_idx[IDX_WIDTH-1:0]];
      end else begin
        rd_value = soc_ctrl_pkg::ERR_PAD_RANGE_DATA;
      end
    end else begin
      case (offs)
        soc_ctrl_pkg::REG_INFO:     rd_value = {16'(NB_CORES), 16'(NB_CLUSTERS)};
        soc_ctrl_pkg::REG_FC_BOOT:  rd_value = fc_bootaddr_o;
        soc_ctrl_pkg::REG_FC_FETCH: rd_value = {31'd0, fc_fetchen_o};
        soc_ctrl_pkg::REG_WCFGFUN,
        soc_ctrl_pkg::REG_RCFGFUN: begin
          rd_value[soc_ctrl_pkg::WCFG_IDX_POS +: IDX_WIDTH]   = sel_pad_q;
          rd_value[soc_ctrl_pkg::WCFG_MUX_POS +: NBIT_PADMUX] = pad_mux_o[sel_pad_q];
          rd_value[soc_ctrl_pkg::WCFG_CFG_POS +: NBIT_PADCFG] = pad_cfg_o[sel_pad_q];
        end
        soc_ctrl_pkg::REG_JTAG: begin
          rd_value[0 +: JTAG_REG_SIZE]             = soc_jtag_reg_o;
          rd_value[JTAG_REG_SIZE +: JTAG_REG_SIZE] = jtag_sync1_q;  // Synchronized input
        end
        soc_ctrl_pkg::REG_WD_COUNT:   rd_value = {1'b0, wd_count_q};
        soc_ctrl_pkg::REG_WD_CONTROL: rd_value = {wd_o.enabled, wd_count_q};
        soc_ctrl_pkg::REG_RTO_PERIPH: rd_value[NB_MASTER-1:0] = periph_flags_i;
        soc_ctrl_pkg::REG_RTO_COUNT:  rd_value = {12'd0, rto_reload_o};
        soc_ctrl_pkg::REG_SOFT_RESET: rd_value = '0;
        default: begin
          rd_value = soc_ctrl_pkg::ERR_UNMAPPED_DATA;
          rd_hit   = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      reg_i.rdata    <= '0;
      reg_i.err      <= 1'b0;
      sel_pad_q      <= '0;
      pad_cfg_o      <= '1;
      pad_mux_o      <= '0;
      jtag_sync0_q   <= '0;
      jtag_sync1_q   <= '0;
      soc_jtag_reg_o <= '0;
      fc_bootaddr_o  <= soc_ctrl_pkg::BOOTADDR_RESET;
      fc_fetchen_o   <= 1'b1;                 // Core fetches straight out of reset
      wd_count_q     <= soc_ctrl_pkg::WD_RESET_COUNT;
      wd_o.start     <= 1'b0;
      wd_o.kick      <= 1'b0;
      rto_reload_o   <= soc_ctrl_pkg::RTO_RESET_COUNT;
      rto_clear_o    <= 1'b0;
      soft_reset_o   <= 1'b0;
    end else begin
      wd_o.start   <= 1'b0;
      wd_o.kick    <= 1'b0;
      rto_clear_o  <= 1'b0;
      soft_reset_o <= 1'b0;

      jtag_sync0_q <= soc_jtag_reg_i;
      jtag_sync1_q <= jtag_sync0_q;

      if (reg_i.rd_en || reg_i.wr_en) begin
        reg_i.rdata <= reg_i.rd_en ? rd_value : '0;
        reg_i.err   <= !rd_hit;
      end

      if (reg_i.wr_en && win_hit) begin
        if (win_in_range) begin
          pad_cfg_o[win_idx[IDX_WIDTH-1:0]] <=
            reg_i.wdata[soc_ctrl_pkg::WIN_CFG_POS +: NBIT_PADCFG];
          pad_mux_o[win_idx[IDX_WIDTH-1:0]] <=
            reg_i.wdata[soc_ctrl_pkg::WIN_MUX_POS +: NBIT_PADMUX];
        end
      end else if (reg_i.wr_en) begin
        case (offs)
          soc_ctrl_pkg::REG_FC_BOOT:  fc_bootaddr_o <= reg_i.wdata;
          soc_ctrl_pkg::REG_FC_FETCH: fc_fetchen_o  <= reg_i.wdata[0];
          soc_ctrl_pkg::REG_WCFGFUN: begin
            sel_pad_q         <= wr_pad;
            pad_cfg_o[wr_pad] <= reg_i.wdata[soc_ctrl_pkg::WCFG_CFG_POS +: NBIT_PADCFG];
            pad_mux_o[wr_pad] <= reg_i.wdata[soc_ctrl_pkg::WCFG_MUX_POS +: NBIT_PADMUX];
          end
          soc_ctrl_pkg::REG_RCFGFUN: sel_pad_q      <= wr_pad;
          soc_ctrl_pkg::REG_JTAG:    soc_jtag_reg_o <= reg_i.wdata[JTAG_REG_SIZE-1:0];
          soc_ctrl_pkg::REG_WD_COUNT: begin
            if (!wd_o.enabled) wd_count_q <= reg_i.wdata[30:0];  // Locked once running
          end
          soc_ctrl_pkg::REG_WD_CONTROL: begin
            if (reg_i.wdata[0]) wd_o.start <= 1'b1;
            if (wd_o.enabled && !wd_o.expired &&
                reg_i.wdata[15:0] == soc_ctrl_pkg::WD_KICK_KEY) begin
              wd_o.kick <= 1'b1;
            end
          end
          soc_ctrl_pkg::REG_RTO_PERIPH: rto_clear_o  <= 1'b1;
          soc_ctrl_pkg::REG_RTO_COUNT:  rto_reload_o <= {reg_i.wdata[19:4], 4'hF};
          soc_ctrl_pkg::REG_SOFT_RESET: begin
            soft_reset_o <= 1'b1;
            sel_pad_q    <= '0;
            pad_cfg_o    <= '1;
            pad_mux_o    <= '0;
            rto_reload_o <= soc_ctrl_pkg::RTO_RESET_COUNT;
            rto_clear_o  <= 1'b1;               // Flags back to reset state
          end
          default: ;
        endcase
      end
    end
  end

  // Front end never issues a read and a write in the same cycle
  a_strobe_excl: assert property (
    @(posedge HCLK) disable iff (!HRESETn) !(reg_i.wr_en && reg_i.rd_en)
  );

endmodule

// File: source/soc_ctrl_apb_fsm.sv
// APB slave front end
// Latches an APB transfer, issues a single-cycle register strobe and
// returns the bank response with a one-cycle PREADY

`timescale 1ns/1ps

module soc_ctrl_apb_fsm (
  input  logic        HCLK,
  input  logic        HRESETn,

  input  logic [11:0] paddr_i,
  input  logic [31:0] pwdata_i,
  input  logic        pwrite_i,
  input  logic        psel_i,
  input  logic        penable_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,

  soc_reg_if.master   reg_o
);

  soc_ctrl_pkg::apb_state_e state_q;

  logic        accept;
  logic [11:0] addr_q;
  logic [31:0] wdata_q;

  // The master still holds its access phase while PREADY is up
  assign accept = psel_i && penable_i && !pready_o;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q   <= soc_ctrl_pkg::APB_IDLE;
      prdata_o  <= '0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      case (state_q)
        soc_ctrl_pkg::APB_IDLE: begin
          if (accept) begin
            state_q <= pwrite_i ? soc_ctrl_pkg::APB_WRITE : soc_ctrl_pkg::APB_READ;
          end
        end
        soc_ctrl_pkg::APB_READ,
        soc_ctrl_pkg::APB_WRITE: begin
          state_q <= soc_ctrl_pkg::APB_WAIT;  // Strobe issued, bank registers response
        end
        soc_ctrl_pkg::APB_WAIT: begin
          pready_o  <= 1'b1;
          prdata_o  <= reg_o.rdata;
          pslverr_o <= reg_o.err;
          state_q   <= soc_ctrl_pkg::APB_IDLE;
        end
        default: state_q <= soc_ctrl_pkg::APB_IDLE;
      endcase
    end
  end

  // Transfer payload
  always_ff @(posedge HCLK) begin
    if (state_q == soc_ctrl_pkg::APB_IDLE && accept) begin
      addr_q  <= paddr_i;
      wdata_q <= pwdata_i;
    end
  end

  assign reg_o.addr  = addr_q;
  assign reg_o.wdata = wdata_q;
  assign reg_o.wr_en = (state_q == soc_ctrl_pkg::APB_WRITE);
  assign reg_o.rd_en = (state_q == soc_ctrl_pkg::APB_READ);

  // Every transfer ends with a single ready cycle
  a_pready_single: assert property (
    @(posedge HCLK) disable iff (!HRESETn) pready_o |=> !pready_o
  );

endmodule

// File: source/soc_wd_if.sv
// Watchdog control channel
// Load value and start/kick pulses from the register bank, status back

`timescale 1ns/1ps

interface soc_wd_if;

  logic [30:0] load_value;
  logic        start;     // One-cycle pulse
  logic        kick;      // One-cycle pulse
  logic        enabled;
  logic        expired;

  modport ctrl (
    output load_value, start, kick,
    input  enabled, expired
  );

  modport timer (
    input  load_value, start, kick,
    output enabled, expired
  );

endinterface

// File: source/soc_reg_if.sv
// Register access channel
// Carries one strobed read or write from the APB front end to the
// register bank, with registered read data and error coming back

`timescale 1ns/1ps

interface soc_reg_if;

  logic [11:0] addr;
  logic [31:0] wdata;
  logic        wr_en;   // One-cycle write strobe
  logic        rd_en;   // One-cycle read strobe
  logic [31:0] rdata;   // Valid the cycle after the strobe
  logic        err;

  modport master (
    output addr, wdata, wr_en, rd_en,
    input  rdata, err
  );

  modport slave (
    input  addr, wdata, wr_en, rd_en,
    output rdata, err
  );

endinterface

// File: source/soc_ctrl_pkg.sv
// SoC control package
// Register map, field positions, reset values and state encodings
// shared by the APB front end, register bank and timers

package soc_ctrl_pkg;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_READ,
    APB_WRITE,
    APB_WAIT
  } apb_state_e;

  typedef enum logic [11:0] {
    REG_INFO       = 12'h000,  // Cores [31:16], clusters [15:0]
    REG_FC_BOOT    = 12'h004,
    REG_FC_FETCH   = 12'h008,
    REG_WCFGFUN    = 12'h060,  // Write mux and cfg of one pad
    REG_RCFGFUN    = 12'h064,  // Select pad for readback
    REG_JTAG       = 12'h074,
    REG_WD_COUNT   = 12'h0D0,
    REG_WD_CONTROL = 12'h0D4,
    REG_RTO_PERIPH = 12'h0E0,
    REG_RTO_COUNT  = 12'h0E4,
    REG_SOFT_RESET = 12'h0FC
  } reg_offset_e;

  localparam logic [11:0] PAD_WINDOW_BASE = 12'h400;  // Direct window 0x400 to 0x7FC

  localparam logic [31:0] BOOTADDR_RESET  = 32'h1A00_0080;
  localparam logic [30:0] WD_RESET_COUNT  = 31'd32768;
  localparam logic [15:0] WD_KICK_KEY     = 16'h6699;
  localparam logic [19:0] RTO_RESET_COUNT = 20'h000FF;

  localparam logic [31:0] ERR_UNMAPPED_DATA  = 32'hDEAD_BEEF;
  localparam logic [31:0] ERR_PAD_RANGE_DATA = 32'h0095_BEEF;

  // wcfgfun and rcfgfun layout
  localparam int WCFG_IDX_POS = 0;
  localparam int WCFG_MUX_POS = 16;
  localparam int WCFG_CFG_POS = 24;

  // Pad window layout
  localparam int WIN_MUX_POS = 0;
  localparam int WIN_CFG_POS = 8;

endpackage
